// ==== compile.f ====
src/vga_pkg.sv
src/vga_timing_gen.sv
src/block_addr_calc.sv
src/frame_write_loader.sv
src/block_frame_memory.sv
src/rgb_output_stage.sv
src/tt_um_vga_block_display.sv
verif/tb_clock_gen.sv
verif/tb_vga_block_display.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the VGA block display testbench with Verilator and run it

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_vga_block_display \
    -f compile.f -o sim_vga > "$BUILD_LOG" 2>&1 \
    || { cat "$BUILD_LOG"; echo "Verilator build error"; exit 1; }

./obj_dir/sim_vga > "$SIM_LOG" 2>&1 \
    || { cat "$SIM_LOG"; echo "Simulation exited with an error"; exit 1; }

cat "$SIM_LOG"
grep -q "Test failed" "$SIM_LOG" \
    && { echo "Simulation FAILED"; exit 1; } \
    || { echo "Simulation passed"; exit 0; }

// ==== src/block_addr_calc.sv ====
`timescale 1ns/100ps
`default_nettype none

module block_addr_calc #(
    parameter int unsigned BLOCK_SHIFT = 4,               // Block edge is 2**BLOCK_SHIFT
    parameter int unsigned BLOCK_COLS  = 40               // Blocks per row
) (
    input  logic               clk,
    input  logic               rst_n,
    input  vga_pkg::scan_pos_t scan,
    output vga_pkg::blk_addr_t rd_addr
);

    logic [9:0]         blk_col;                          // Block column of pixel
    logic [9:0]         blk_row;                          // Block row of pixel
    vga_pkg::blk_addr_t addr_nxt;                         // Linear block index

    always_comb begin
        blk_col  = scan.x >> BLOCK_SHIFT;
        blk_row  = scan.y >> BLOCK_SHIFT;
        // Row major layout, row stride of BLOCK_COLS
        addr_nxt = vga_pkg::blk_addr_t'(blk_row * BLOCK_COLS + blk_col);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_addr <= '0;
        end else begin
            rd_addr <= addr_nxt;                          // One cycle behind scan
        end
    end

endmodule

`default_nettype wire

// ==== src/block_frame_memory.sv ====
`timescale 1ns/100ps
`default_nettype none

module block_frame_memory #(
    parameter int unsigned BLOCK_COUNT = 1200             // Number of blocks stored
) (
    input  logic               clk,
    input  logic               rst_n,
    input  vga_pkg::blk_addr_t rd_addr,
    input  vga_pkg::fb_write_t wr_req,
    output vga_pkg::rgb_t      rd_rgb
);

    vga_pkg::rgb_t mem [BLOCK_COUNT];                     // One colour per block
    logic          wr_hit;                                // Write lands in range
    logic          rd_hit;                                // Read lands in range

    assign wr_hit = wr_req.valid && (wr_req.addr < BLOCK_COUNT);
    // Blanking rows map past the last block
    assign rd_hit = (rd_addr < BLOCK_COUNT);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < BLOCK_COUNT; i++) begin
                mem[i] <= '0;                             // Screen starts black
            end
        end else if (wr_hit) begin
            mem[wr_req.addr] <= wr_req.rgb;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_rgb <= '0;
        end else begin
            rd_rgb <= rd_hit ? mem[rd_addr] : '0;         // Registered read
        end
    end

    // Host must only address existing blocks
    a_wr_addr_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        wr_req.valid |-> (wr_req.addr < BLOCK_COUNT)
    ) else $error("block_frame_memory: write address %0d out of range", wr_req.addr);

endmodule

`default_nettype wire

// ==== src/frame_write_loader.sv ====
`timescale 1ns/100ps
`default_nettype none

module frame_write_loader (
    input  logic               clk,
    input  logic               rst_n,
    input  vga_pkg::blk_addr_t wr_addr,
    input  vga_pkg::rgb_t      wr_rgb,
    input  logic               wr_strobe,
    input  logic               active,
    output vga_pkg::fb_write_t wr_req
);

    vga_pkg::loader_state_t state;                        // Current FSM state
    vga_pkg::loader_state_t state_nxt;
    logic                   strobe_q;                     // Strobe one cycle ago
    logic                   strobe_rise;                  // 0 to 1 transition
    vga_pkg::blk_addr_t     pend_addr;                    // Held request address
    vga_pkg::rgb_t          pend_rgb;                     // Held request colour

    assign strobe_rise = wr_strobe && !strobe_q;

    always_comb begin
        state_nxt = state;
        if (strobe_rise) begin
            state_nxt = vga_pkg::LD_PENDING;              // New edge, newest wins
        end else if ((state == vga_pkg::LD_PENDING) && !active) begin
            state_nxt = vga_pkg::LD_IDLE;                 // Commit done this cycle
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= vga_pkg::LD_IDLE;
            strobe_q <= 1'b0;
        end else begin
            state    <= state_nxt;
            strobe_q <= wr_strobe;
        end
    end

    always_ff @(posedge clk) begin
        if (strobe_rise) begin
            pend_addr <= wr_addr;                         // Overwrites any older request
            pend_rgb  <= wr_rgb;
        end
    end

    // Write fires in the first blanking cycle of a pending request
    assign wr_req.valid = (state == vga_pkg::LD_PENDING) && !active;
    assign wr_req.addr  = pend_addr;
    assign wr_req.rgb   = pend_rgb;

    a_no_write_active: assert property (
        @(posedge clk) disable iff (!rst_n)
        wr_req.valid |-> !active
    ) else $error("frame_write_loader: write during active video");

endmodule

`default_nettype wire

// ==== src/rgb_output_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module rgb_output_stage (
    input  logic               clk,
    input  logic               rst_n,
    input  vga_pkg::scan_pos_t scan,
    input  vga_pkg::rgb_t      rd_rgb,
    output logic [7:0]         vga_out
);

    logic [2:0] ctl_d1;                                   // {active, hs, vs}, 1 cycle late
    logic [2:0] ctl_d2;                                   // 2 cycles late, matches rd_rgb
    logic       act_d2;
    logic       hs_d2;
    logic       vs_d2;

    // Address and read each cost a cycle, so the sync path waits two
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ctl_d1 <= 3'b011;                             // Blanked, syncs idle
            ctl_d2 <= 3'b011;
        end else begin
            ctl_d1 <= {scan.active, scan.hs, scan.vs};
            ctl_d2 <= ctl_d1;
        end
    end

    assign {act_d2, hs_d2, vs_d2} = ctl_d2;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vga_out <= 8'b0000_0011;                      // Black, syncs high
        end else begin
            vga_out[0] <= hs_d2;
            vga_out[1] <= vs_d2;
            if (act_d2) begin
                // Each colour bit fills both bits of its pair
                vga_out[7:2] <= {{2{rd_rgb.r}}, {2{rd_rgb.g}}, {2{rd_rgb.b}}};
            end else begin
                vga_out[7:2] <= 6'd0;                     // Blank outside picture
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/tt_um_vga_block_display.sv ====
`timescale 1ns/100ps
`default_nettype none

module tt_um_vga_block_display #(
    parameter int unsigned BLOCK_SHIFT = 4,               // 16 pixel blocks
    parameter int unsigned BLOCK_COLS  = 40,              // 640 / 16
    parameter int unsigned BLOCK_COUNT = 1200             // 40 x 30
) (
    input  logic [7:0] ui_in,                             // Write address low byte
    output logic [7:0] uo_out,                            // Syncs and RGB222
    input  logic [7:0] uio_in,                            // Address high, colour, strobe
    output logic [7:0] uio_out,
    output logic [7:0] uio_oe,
    input  logic       ena,                               // Not used
    input  logic       clk,                               // Pixel clock
    input  logic       rst_n
);

    vga_pkg::scan_pos_t scan;                             // Timing generator state
    vga_pkg::blk_addr_t rd_addr;                          // Block under the beam
    vga_pkg::rgb_t      rd_rgb;                           // Its stored colour
    vga_pkg::fb_write_t wr_req;                           // Commit from loader
    vga_pkg::blk_addr_t wr_addr;
    vga_pkg::rgb_t      wr_rgb;
    logic               wr_strobe;

    assign wr_addr   = {uio_in[2:0], ui_in};              // 11-bit block index
    assign wr_rgb    = uio_in[5:3];                       // r on bit 5, b on bit 3
    assign wr_strobe = uio_in[7];

    vga_timing_gen timing_i (
        .clk   (clk),
        .rst_n (rst_n),
        .scan  (scan)
    );

    block_addr_calc #(
        .BLOCK_SHIFT (BLOCK_SHIFT),
        .BLOCK_COLS  (BLOCK_COLS)
    ) addr_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .scan    (scan),
        .rd_addr (rd_addr)
    );

    frame_write_loader loader_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr_addr   (wr_addr),
        .wr_rgb    (wr_rgb),
        .wr_strobe (wr_strobe),
        .active    (scan.active),
        .wr_req    (wr_req)
    );

    block_frame_memory #(
        .BLOCK_COUNT (BLOCK_COUNT)
    ) mem_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .rd_addr (rd_addr),
        .wr_req  (wr_req),
        .rd_rgb  (rd_rgb)
    );

    rgb_output_stage out_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .scan    (scan),
        .rd_rgb  (rd_rgb),
        .vga_out (uo_out)
    );

    assign uio_out = 8'h00;                               // Bidirectional pins stay inputs
    assign uio_oe  = 8'h00;

endmodule

`default_nettype wire

// ==== src/vga_pkg.sv ====
`default_nettype none

package vga_pkg;

    // Horizontal timing, in pixel clocks
    localparam logic [9:0] H_VISIBLE = 10'd640;           // Visible pixels per line
    localparam logic [9:0] H_FRONT   = 10'd16;            // Front porch
    localparam logic [9:0] H_SYNC    = 10'd96;            // Sync pulse width
    localparam logic [9:0] H_BACK    = 10'd48;            // Back porch
    localparam logic [9:0] H_TOTAL   = H_VISIBLE + H_FRONT + H_SYNC + H_BACK;  // 800

    // Vertical timing, in lines
    localparam logic [9:0] V_VISIBLE = 10'd480;           // Visible lines per frame
    localparam logic [9:0] V_FRONT   = 10'd10;            // Front porch
    localparam logic [9:0] V_SYNC    = 10'd2;             // Sync pulse height
    localparam logic [9:0] V_BACK    = 10'd33;            // Back porch
    localparam logic [9:0] V_TOTAL   = V_VISIBLE + V_FRONT + V_SYNC + V_BACK;  // 525

    // One bit per colour channel
    typedef struct packed {
        logic r;                                          // Red
        logic g;                                          // Green
        logic b;                                          // Blue
    } rgb_t;

    // Timing generator state, one word per pixel clock
    typedef struct packed {
        logic [9:0] x;                                    // Column counter
        logic [9:0] y;                                    // Line counter
        logic       active;                               // Inside visible area
        logic       hs;                                   // Hsync, active low
        logic       vs;                                   // Vsync, active low
    } scan_pos_t;

    typedef logic [10:0] blk_addr_t;                      // Block index 0..1199

    // Single write request into the block memory
    typedef struct packed {
        logic      valid;                                 // Commit this cycle
        blk_addr_t addr;                                  // Target block
        rgb_t      rgb;                                   // New colour
    } fb_write_t;

    typedef enum logic {
        LD_IDLE    = 1'b0,                                // Nothing held
        LD_PENDING = 1'b1                                 // Request waits for blanking
    } loader_state_t;

endpackage

`default_nettype wire

// ==== src/vga_timing_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

module vga_timing_gen (
    input  logic               clk,
    input  logic               rst_n,
    output vga_pkg::scan_pos_t scan
);

    // Sync windows derived from the porch widths
    localparam logic [9:0] HS_START = vga_pkg::H_VISIBLE + vga_pkg::H_FRONT;  // 656
    localparam logic [9:0] HS_END   = HS_START + vga_pkg::H_SYNC;             // 752
    localparam logic [9:0] VS_START = vga_pkg::V_VISIBLE + vga_pkg::V_FRONT;  // 490
    localparam logic [9:0] VS_END   = VS_START + vga_pkg::V_SYNC;             // 492

    logic       line_end;                                 // Last pixel of a line
    logic       frame_end;                                // Last line of a frame
    logic [9:0] x_nxt;                                    // Column for next cycle
    logic [9:0] y_nxt;                                    // Line for next cycle

    always_comb begin
        line_end  = (scan.x == vga_pkg::H_TOTAL - 10'd1);
        frame_end = (scan.y == vga_pkg::V_TOTAL - 10'd1);
        x_nxt     = line_end ? 10'd0 : scan.x + 10'd1;    // Wrap at 799
        y_nxt     = scan.y;                               // Hold mid-line
        if (line_end) begin
            y_nxt = frame_end ? 10'd0 : scan.y + 10'd1;   // Wrap at 524
        end
    end

    // Flags are decoded from the next position so they land with x and y
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            scan.x      <= 10'd0;
            scan.y      <= 10'd0;
            scan.active <= 1'b1;                          // Position 0,0 is visible
            scan.hs     <= 1'b1;                          // Sync idle high
            scan.vs     <= 1'b1;
        end else begin
            scan.x      <= x_nxt;
            scan.y      <= y_nxt;
            scan.active <= (x_nxt < vga_pkg::H_VISIBLE) && (y_nxt < vga_pkg::V_VISIBLE);
            scan.hs     <= !((x_nxt >= HS_START) && (x_nxt < HS_END));
            scan.vs     <= !((y_nxt >= VS_START) && (y_nxt < VS_END));
        end
    end

    // Column counter stays inside one line period
    a_x_in_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        scan.x < vga_pkg::H_TOTAL
    ) else $error("vga_timing_gen: x reached H_TOTAL");

endmodule

`default_nettype wire

// ==== verif/tb_clock_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen #(
    parameter int unsigned HALF_PERIOD_NS = 2,            // 4 ns pixel clock
    parameter int unsigned RESET_CYCLES   = 16            // Cycles held in reset
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD_NS) clk = ~clk;
    end

    // Release just after a rising edge, away from the sampling edge
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// ==== verif/tb_vga_block_display.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_vga_block_display;

    localparam int H_VIS = 640;                           // Visible columns
    localparam int V_VIS = 480;                           // Visible lines
    localparam int H_TOT = 800;
    localparam int V_TOT = 525;
    localparam int HS_LO_FIRST = 656;                     // Hsync low window
    localparam int HS_LO_LAST  = 751;
    localparam int VS_LO_FIRST = 490;                     // Vsync low lines
    localparam int VS_LO_LAST  = 491;
    localparam int BLK = 16;                              // Block edge in pixels
    localparam int COLS = 40;
    localparam int NUM_BLOCKS = 1200;
    localparam int TBL_LEN = 16;                          // 4 fixed plus 12 random
    localparam int ACT_BLK = 5;                           // Row 0, already drawn at line 100
    localparam int RESET_CYCLES = 16;
    localparam int CLK_PERIOD_NS = 4;
    // Five frames plus reset, about 8.4 ms
    localparam int WATCHDOG_NS = (5 * H_TOT * V_TOT + RESET_CYCLES) * CLK_PERIOD_NS;

    logic       clk;
    logic       rst_n;
    logic [7:0] ui_in;
    logic [7:0] uio_in;
    logic       ena;
    logic [7:0] uo_out;
    logic [7:0] uio_out;
    logic [7:0] uio_oe;

    logic [10:0] tbl_addr [TBL_LEN];                      // Stimulus table, block index
    logic [2:0]  tbl_rgb  [TBL_LEN];                      // Colour {r, g, b}
    logic [2:0]  model    [NUM_BLOCKS];                   // Expected colour per block

    int   error_count;
    int   pixels_checked;
    int   vs_falls;                                       // Vsync falling edges seen
    int   sx;                                             // Position rebuilt from uo_out
    int   sy;
    int   hs_low_cnt;
    int   vs_low_cnt;
    logic synced;
    logic prev_vs;

    tb_clock_gen #(
        .HALF_PERIOD_NS (CLK_PERIOD_NS / 2),
        .RESET_CYCLES   (RESET_CYCLES)
    ) clk_gen_i (
        .clk   (clk),
        .rst_n (rst_n)
    );

    tt_um_vga_block_display #(
        .BLOCK_SHIFT (4),
        .BLOCK_COLS  (40),
        .BLOCK_COUNT (1200)
    ) dut_i (
        .ui_in   (ui_in),
        .uo_out  (uo_out),
        .uio_in  (uio_in),
        .uio_out (uio_out),
        .uio_oe  (uio_oe),
        .ena     (ena),
        .clk     (clk),
        .rst_n   (rst_n)
    );

    function automatic logic [5:0] expand_colour(input logic [2:0] c);
        return {c[2], c[2], c[1], c[1], c[0], c[0]};      // Pin order r r g g b b
    endfunction

    // Compares one uo_out sample with the rebuilt position
    task automatic check_sample();
        logic       exp_hs;
        logic       exp_vs;
        logic [5:0] exp_rgb;
        exp_hs = !(sx >= HS_LO_FIRST && sx <= HS_LO_LAST);
        exp_vs = !(sy >= VS_LO_FIRST && sy <= VS_LO_LAST);
        if (sx == 0) begin
            hs_low_cnt = 0;
        end
        if (sx == 0 && sy == 0) begin
            vs_low_cnt = 0;
        end
        hs_low_cnt += int'(!uo_out[0]);
        vs_low_cnt += int'(!uo_out[1]);
        exp_rgb = 6'd0;                                   // Blanked outside picture
        if (sx < H_VIS && sy < V_VIS) begin
            exp_rgb = expand_colour(model[(sy / BLK) * COLS + sx / BLK]);
            pixels_checked++;
        end
        if (uo_out[0] !== exp_hs || uo_out[1] !== exp_vs) begin
            error_count++;
            $display("mismatch at %0t: sync at x=%0d y=%0d got hs=%b vs=%b expected hs=%b vs=%b",
                     $time, sx, sy, uo_out[0], uo_out[1], exp_hs, exp_vs);
        end
        if (uo_out[7:2] !== exp_rgb) begin
            error_count++;
            $display("mismatch at %0t: colour at x=%0d y=%0d got %b expected %b",
                     $time, sx, sy, uo_out[7:2], exp_rgb);
        end
        if (sx == H_TOT - 1 && hs_low_cnt != HS_LO_LAST - HS_LO_FIRST + 1) begin
            error_count++;
            $display("mismatch at %0t: hsync low %0d cycles in line %0d, expected 96",
                     $time, hs_low_cnt, sy);
        end
        if (sx == H_TOT - 1 && sy == V_TOT - 1 && vs_low_cnt != 2 * H_TOT) begin
            error_count++;
            $display("mismatch at %0t: vsync low %0d cycles in frame, expected 1600",
                     $time, vs_low_cnt);
        end
    endtask

    // One strobe pulse carrying address and colour
    task automatic pulse_write(input logic [10:0] addr, input logic [2:0] rgb);
        @(posedge clk);
        #1;
        ui_in  = addr[7:0];
        uio_in = {1'b1, 1'b0, rgb, addr[10:8]};           // Strobe, spare, r g b, addr high
        @(posedge clk);
        #1;
        uio_in[7] = 1'b0;
    endtask

    task automatic wait_vs_falls(input int count);
        while (vs_falls < count) begin
            @(posedge clk);
        end
    endtask

    task automatic wait_position(input int frame_no, input int y, input int x);
        do begin
            @(posedge clk);
        end while (!(vs_falls == frame_no && sy == y && sx == x));
    endtask

    // Sampler anchors on the vsync fall, which shows line 490 column 0
    always @(negedge clk) begin
        if (uio_out !== 8'h00 || uio_oe !== 8'h00) begin
            error_count++;
            $display("mismatch at %0t: uio_out=%h uio_oe=%h expected 00", $time, uio_out, uio_oe);
        end
        if (!rst_n) begin
            prev_vs = 1'b1;
            synced  = 1'b0;
        end else begin
            if (synced) begin
                sx = (sx == H_TOT - 1) ? 0 : sx + 1;
                if (sx == 0) begin
                    sy = (sy == V_TOT - 1) ? 0 : sy + 1;
                end
            end
            if (prev_vs && !uo_out[1]) begin
                if (synced && (sx != 0 || sy != VS_LO_FIRST)) begin
                    error_count++;
                    $display("mismatch at %0t: vsync fell at x=%0d y=%0d", $time, sx, sy);
                end
                sx         = 0;
                sy         = VS_LO_FIRST;
                synced     = 1'b1;
                vs_low_cnt = 0;
                vs_falls++;
            end
            prev_vs = uo_out[1];
            if (synced) begin
                check_sample();
            end
        end
    end

    initial begin
        int         rnd;
        logic [2:0] old_rgb;
        logic [2:0] first_rgb;
        logic [2:0] last_rgb;
        ui_in          = 8'h00;
        uio_in         = 8'h00;
        ena            = 1'b1;
        error_count    = 0;
        pixels_checked = 0;
        vs_falls       = 0;
        sx             = 0;
        sy             = 0;
        hs_low_cnt     = 0;
        vs_low_cnt     = 0;
        for (int i = 0; i < NUM_BLOCKS; i++) begin
            model[i] = 3'b000;                            // Memory clears on reset
        end
        rnd = $urandom(32'h1e3e);
        tbl_addr[0] = 11'd0;                              // Corners and row edges
        tbl_rgb[0]  = 3'b100;
        tbl_addr[1] = 11'd39;
        tbl_rgb[1]  = 3'b010;
        tbl_addr[2] = 11'd40;
        tbl_rgb[2]  = 3'b001;
        tbl_addr[3] = 11'd1199;
        tbl_rgb[3]  = 3'b111;
        for (int i = 4; i < TBL_LEN; i++) begin
            rnd         = int'($urandom % NUM_BLOCKS);
            tbl_addr[i] = 11'(rnd);
            tbl_rgb[i]  = 3'($urandom);
        end

        @(negedge clk);
        while (!rst_n) begin
            if (uo_out !== 8'h03) begin
                error_count++;
                $display("mismatch at %0t: uo_out=%b during reset, expected 00000011",
                         $time, uo_out);
            end
            @(negedge clk);
        end

        // Frame 1 is checked black, table goes in during its vertical blanking
        wait_vs_falls(2);
        for (int i = 0; i < TBL_LEN; i++) begin
            pulse_write(tbl_addr[i], tbl_rgb[i]);
            model[tbl_addr[i]] = tbl_rgb[i];
        end

        // Two writes to one block inside an active line of frame 3
        wait_position(3, 100, 20);
        old_rgb   = model[ACT_BLK];
        last_rgb  = ~old_rgb;
        first_rgb = last_rgb ^ 3'b011;                    // Differs from old and last
        pulse_write(11'(ACT_BLK), first_rgb);
        pulse_write(11'(ACT_BLK), last_rgb);
        wait_vs_falls(4);
        model[ACT_BLK] = last_rgb;                        // Expected from frame 4 on
        wait_vs_falls(5);

        if (pixels_checked != 4 * H_VIS * V_VIS) begin
            error_count++;
            $display("Only %0d visible pixels were checked, expected %0d",
                     pixels_checked, 4 * H_VIS * V_VIS);
        end
        $display("errors: %0d, visible pixels checked: %0d", error_count, pixels_checked);
        if (error_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: run did not finish within %0d ns", WATCHDOG_NS);
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire
